//--- acc_dims_pkg.sv
`default_nettype none

package acc_dims_pkg;

    // channel count of the array
    localparam int LANES = 4;
    // activation and weight width
    localparam int DATA_W = 8;
    // accumulator, bias and result width
    localparam int ACC_W = 32;
    // scale is unsigned
    localparam int SCALE_W = 16;
    localparam int SCALE_SHIFT = 8;
    // group lengths 1..16
    localparam int LEN_W = 5;
    localparam int IDX_W = 2;
    // one input word, one acc_t per lane
    localparam int WORD_W = LANES * ACC_W;
    // single 8x8 product
    localparam int PROD_W = 2 * DATA_W;
    // (sum + bias) times zero-extended scale
    localparam int MUL_W = ACC_W + SCALE_W + 1;

endpackage

`default_nettype wire

//--- acc_stream_pkg.sv
`default_nettype none

package acc_stream_pkg;

    import acc_dims_pkg::*;

    // tag carried with every read-data word
    typedef enum logic [1:0] {
        KIND_DATA   = 2'd0,
        KIND_WEIGHT = 2'd1,
        KIND_BIAS   = 2'd2,
        KIND_SCALE  = 2'd3
    } word_kind_e;

    // ----------------------------------------
    // lane element types
    // ----------------------------------------
    // named signed elements keep their sign when indexed out of a vector
    typedef logic signed [DATA_W-1:0] act_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [SCALE_W-1:0]       scale_t;

    // ----------------------------------------
    // vectors
    // ----------------------------------------
    // one beat, also one weight row
    typedef act_t [LANES-1:0] act_vec_t;
    // sums, bias and results
    typedef acc_t [LANES-1:0] acc_vec_t;
    typedef scale_t [LANES-1:0] scale_vec_t;
    // row j feeds output lane j
    typedef act_vec_t [LANES-1:0] weight_mat_t;

endpackage

`default_nettype wire

//--- coef_load_if.sv
`timescale 1ns/10ps
`default_nettype none

interface coef_load_if;

    import acc_dims_pkg::*;
    import acc_stream_pkg::*;

    // write strobe, one word per cycle
    logic             vld;
    // which bank the word belongs to
    word_kind_e       kind;
    // weight row, ignored by bias and scale
    logic [IDX_W-1:0] index;
    logic [WORD_W-1:0] data;

    // demux side drives everything
    modport demux (
        output vld,
        output kind,
        output index,
        output data
    );

    // every bank sees every write and filters on kind
    modport bank (
        input vld,
        input kind,
        input index,
        input data
    );

endinterface

`default_nettype wire

//--- rd_data_demux.sv
`timescale 1ns/10ps
`default_nettype none

module rd_data_demux (
    input  logic                            clk_calc,
    input  logic                            rst_n,
    input  logic                            in_vld,
    input  acc_stream_pkg::word_kind_e      in_kind,
    input  logic [acc_dims_pkg::IDX_W-1:0]  in_index,
    input  logic [acc_dims_pkg::WORD_W-1:0] in_data,
    output logic                            beat_vld,
    output acc_stream_pkg::act_vec_t        beat,
    coef_load_if.demux                      load
);

    import acc_dims_pkg::*;
    import acc_stream_pkg::*;

    logic             vld_q;
    word_kind_e       kind_q;
    logic [IDX_W-1:0] index_q;
    logic [WORD_W-1:0] data_q;
    logic             is_data;
    logic             is_coef;

    // ----------------------------------------
    // input capture
    // ----------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            vld_q   <= 1'b0;
            kind_q  <= KIND_DATA;
            index_q <= '0;
            data_q  <= '0;
        end else begin
            vld_q <= in_vld;
            // hold last word when idle
            if (in_vld) begin
                kind_q  <= in_kind;
                index_q <= in_index;
                data_q  <= in_data;
            end
        end
    end

    // data words go to the array, everything else to the banks
    assign is_data = vld_q && (kind_q == KIND_DATA);
    assign is_coef = vld_q && (kind_q != KIND_DATA);

    // ----------------------------------------
    // split
    // ----------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            beat_vld   <= 1'b0;
            beat       <= '0;
            load.vld   <= 1'b0;
            load.kind  <= KIND_DATA;
            load.index <= '0;
            load.data  <= '0;
        end else begin
            beat_vld <= is_data;
            load.vld <= is_coef;
            // activations sit in the low bytes of the word
            if (is_data) begin
                beat <= act_vec_t'(data_q[LANES*DATA_W-1:0]);
            end
            if (is_coef) begin
                load.kind  <= kind_q;
                load.index <= index_q;
                load.data  <= data_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- coef_bank.sv
`timescale 1ns/10ps
`default_nettype none

module coef_bank #(
    parameter type entry_t = logic,
    parameter int DEPTH = 1,
    parameter acc_stream_pkg::word_kind_e LOAD_KIND = acc_stream_pkg::KIND_WEIGHT
) (
    input  logic                 clk_calc,
    input  logic                 rst_n,
    coef_load_if.bank            load,
    output entry_t [DEPTH-1:0]   entries
);

    import acc_dims_pkg::*;

    // entry width decides how much of the word is kept
    localparam int ENTRY_W = $bits(entry_t);

    logic   kind_hit;
    entry_t new_entry;

    // only writes tagged for this bank
    assign kind_hit = load.vld && (load.kind == LOAD_KIND);

    // low bits of the word, reinterpreted as one entry
    assign new_entry = entry_t'(load.data[ENTRY_W-1:0]);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            entries <= '0;
        end else if (kind_hit) begin
            for (int i = 0; i < DEPTH; i++) begin
                // single-entry banks ignore the index
                if ((DEPTH == 1) || (load.index == IDX_W'(i))) begin
                    entries[i] <= new_entry;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mac_array.sv
`timescale 1ns/10ps
`default_nettype none

module mac_array (
    input  logic                            clk_calc,
    input  logic                            rst_n,
    input  logic                            beat_vld,
    input  acc_stream_pkg::act_vec_t        beat,
    input  acc_stream_pkg::weight_mat_t     weights,
    input  logic [acc_dims_pkg::LEN_W-1:0]  acc_len,
    output logic                            sum_vld,
    output acc_stream_pkg::acc_vec_t        sum
);

    import acc_dims_pkg::*;
    import acc_stream_pkg::*;

    typedef logic signed [PROD_W-1:0] prod_t;

    // group tracking
    logic [LEN_W-1:0] beat_cnt;
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] cur_len;
    logic             is_last;

    // stage 1 regs
    logic                           p1_vld;
    logic                           p1_last;
    prod_t [LANES-1:0][LANES-1:0]   prod_q;

    // stage 2
    acc_vec_t row_sum;
    acc_vec_t acc_q;

    // ----------------------------------------
    // beat counter
    // ----------------------------------------
    // acc_len is only trusted on the first beat
    assign cur_len = (beat_cnt == '0) ? acc_len : len_q;
    // >= so a zero length behaves as one
    assign is_last = (beat_cnt + LEN_W'(1)) >= cur_len;

    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            len_q    <= '0;
        end else if (beat_vld) begin
            if (beat_cnt == '0) begin
                len_q <= acc_len;
            end
            beat_cnt <= is_last ? '0 : beat_cnt + LEN_W'(1);
        end
    end

    // ----------------------------------------
    // stage 1: products
    // ----------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            p1_vld  <= 1'b0;
            p1_last <= 1'b0;
            prod_q  <= '0;
        end else begin
            p1_vld  <= beat_vld;
            p1_last <= beat_vld && is_last;
            if (beat_vld) begin
                // row j against the whole beat
                for (int j = 0; j < LANES; j++) begin
                    for (int k = 0; k < LANES; k++) begin
                        prod_q[j][k] <= beat[k] * weights[j][k];
                    end
                end
            end
        end
    end

    // row sums, sign-extended into the accumulator width
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            row_sum[j] = '0;
            for (int k = 0; k < LANES; k++) begin
                row_sum[j] = row_sum[j] + acc_t'(prod_q[j][k]);
            end
        end
    end

    // ----------------------------------------
    // stage 2: accumulate
    // ----------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            acc_q   <= '0;
            sum     <= '0;
            sum_vld <= 1'b0;
        end else begin
            sum_vld <= p1_vld && p1_last;
            if (p1_vld) begin
                for (int j = 0; j < LANES; j++) begin
                    if (p1_last) begin
                        // emit and restart for the next group
                        sum[j]   <= acc_q[j] + row_sum[j];
                        acc_q[j] <= '0;
                    end else begin
                        acc_q[j] <= acc_q[j] + row_sum[j];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bias_scale_relu.sv
`timescale 1ns/10ps
`default_nettype none

module bias_scale_relu (
    input  logic                        clk_calc,
    input  logic                        rst_n,
    input  logic                        sum_vld,
    input  acc_stream_pkg::acc_vec_t    sum,
    input  acc_stream_pkg::acc_vec_t    bias,
    input  acc_stream_pkg::scale_vec_t  scale,
    input  logic                        relu_en,
    output logic                        out_vld,
    output acc_stream_pkg::acc_vec_t    out_data
);

    import acc_dims_pkg::*;
    import acc_stream_pkg::*;

    typedef logic signed [MUL_W-1:0] mul_t;

    acc_vec_t          biased;
    mul_t [LANES-1:0]  mul_d;
    mul_t [LANES-1:0]  mul_q;
    logic              p1_vld;
    mul_t [LANES-1:0]  shr;
    acc_vec_t          lane_out;

    // ----------------------------------------
    // stage 1: bias and scale
    // ----------------------------------------
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            // bias add wraps at ACC_W
            biased[j] = sum[j] + bias[j];
            // scale is unsigned, extra zero keeps it positive
            mul_d[j]  = biased[j] * $signed({1'b0, scale[j]});
        end
    end

    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            p1_vld <= 1'b0;
            mul_q  <= '0;
        end else begin
            p1_vld <= sum_vld;
            if (sum_vld) begin
                mul_q <= mul_d;
            end
        end
    end

    // ----------------------------------------
    // stage 2: shift, truncate, relu
    // ----------------------------------------
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            shr[j]      = mul_q[j] >>> SCALE_SHIFT;
            lane_out[j] = acc_t'(shr[j][ACC_W-1:0]);
            // sign of the truncated lane decides relu
            if (relu_en && lane_out[j][ACC_W-1]) begin
                lane_out[j] = '0;
            end
        end
    end

    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            out_vld  <= 1'b0;
            out_data <= '0;
        end else begin
            out_vld <= p1_vld;
            if (p1_vld) begin
                out_data <= lane_out;
            end
        end
    end

endmodule

`default_nettype wire

//--- mobilenet_acc_top.sv
`timescale 1ns/10ps
`default_nettype none

module mobilenet_acc_top (
    input  logic                            clk_calc,
    input  logic                            rst_n,
    input  logic                            in_vld,
    input  acc_stream_pkg::word_kind_e      in_kind,
    input  logic [acc_dims_pkg::IDX_W-1:0]  in_index,
    input  logic [acc_dims_pkg::WORD_W-1:0] in_data,
    input  logic [acc_dims_pkg::LEN_W-1:0]  acc_len,
    input  logic                            relu_en,
    output logic                            out_vld,
    output acc_stream_pkg::acc_vec_t        out_data
);

    import acc_dims_pkg::*;
    import acc_stream_pkg::*;

    // demux to array
    logic        beat_vld;
    act_vec_t    beat;
    // bank outputs
    weight_mat_t weights;
    acc_vec_t    bias;
    scale_vec_t  scale;
    // array to post stage
    logic        sum_vld;
    acc_vec_t    sum;

    // coefficient writes, shared by all banks
    coef_load_if load_bus ();

    // ----------------------------------------
    // read-data split
    // ----------------------------------------
    rd_data_demux u_demux (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .in_vld   (in_vld),
        .in_kind  (in_kind),
        .in_index (in_index),
        .in_data  (in_data),
        .beat_vld (beat_vld),
        .beat     (beat),
        .load     (load_bus.demux)
    );

    // ----------------------------------------
    // coefficient banks
    // ----------------------------------------
    // one row per output lane
    coef_bank #(
        .entry_t   (act_vec_t),
        .DEPTH     (LANES),
        .LOAD_KIND (KIND_WEIGHT)
    ) u_weight_bank (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .load     (load_bus.bank),
        .entries  (weights)
    );

    coef_bank #(
        .entry_t   (acc_vec_t),
        .DEPTH     (1),
        .LOAD_KIND (KIND_BIAS)
    ) u_bias_bank (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .load     (load_bus.bank),
        .entries  (bias)
    );

    coef_bank #(
        .entry_t   (scale_vec_t),
        .DEPTH     (1),
        .LOAD_KIND (KIND_SCALE)
    ) u_scale_bank (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .load     (load_bus.bank),
        .entries  (scale)
    );

    // ----------------------------------------
    // compute path
    // ----------------------------------------
    mac_array u_mac (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .beat_vld (beat_vld),
        .beat     (beat),
        .weights  (weights),
        .acc_len  (acc_len),
        .sum_vld  (sum_vld),
        .sum      (sum)
    );

    bias_scale_relu u_post (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .sum_vld  (sum_vld),
        .sum      (sum),
        .bias     (bias),
        .scale    (scale),
        .relu_en  (relu_en),
        .out_vld  (out_vld),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

//--- tb_mobilenet_acc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mobilenet_acc;

    import acc_dims_pkg::*;
    import acc_stream_pkg::*;

    // one row of the stimulus table
    typedef struct {
        string       name;
        bit          rand_w;
        weight_mat_t w;
        acc_vec_t    b;
        scale_vec_t  s;
        bit          relu;
        // zero draws a length of 2..16
        int          len;
        int          groups;
        bit          rand_beats;
        act_vec_t    beat;
    } test_entry_t;

    // one result the monitor waits for
    typedef struct {
        string    name;
        acc_vec_t data;
        int       cycle;
    } expect_t;

    logic                 clk_calc;
    logic                 rst_n;
    logic                 in_vld;
    word_kind_e           in_kind;
    logic [IDX_W-1:0]     in_index;
    logic [WORD_W-1:0]    in_data;
    logic [LEN_W-1:0]     acc_len;
    logic                 relu_en;
    logic                 out_vld;
    acc_vec_t             out_data;

    integer               seed = 16756;
    int                   cycle_cnt = 0;
    string                cur_name = "reset";
    test_entry_t          table_q[$];
    expect_t              exp_q[$];
    // beats of the current group for the model
    act_vec_t             grp_beats[$];

    mobilenet_acc_top UUT (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .in_vld   (in_vld),
        .in_kind  (in_kind),
        .in_index (in_index),
        .in_data  (in_data),
        .acc_len  (acc_len),
        .relu_en  (relu_en),
        .out_vld  (out_vld),
        .out_data (out_data)
    );

    initial begin
        clk_calc = 1'b0;
        forever #5 clk_calc = ~clk_calc;
    end

    // rising edges seen so far
    always @(posedge clk_calc)
        cycle_cnt <= cycle_cnt + 1;

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic stop_sim();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_vec(input string name, input acc_vec_t exp, input acc_vec_t act);
        if (exp !== act) begin
            $display("FAIL %s out_data expected %h actual %h", name, exp, act);
            stop_sim();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s out_vld expected %b actual %b", name, exp, act);
            stop_sim();
        end
    endtask

    // out_vld must be high exactly on the cycle the head result is due
    always @(negedge clk_calc) begin
        logic due;
        due = (exp_q.size() > 0) && (exp_q[0].cycle == cycle_cnt);
        check_bit(cur_name, due, out_vld);
        if (due) begin
            check_vec(exp_q[0].name, exp_q[0].data, out_data);
            void'(exp_q.pop_front());
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // dot product over the group then bias, scale, shift by 8 and optional relu
    function automatic acc_vec_t expected_result(input weight_mat_t w, input acc_vec_t b,
                                                 input scale_vec_t s, input bit relu);
        acc_vec_t res;
        int       dot;
        int       x;
        int       wt;
        int       biased;
        int       r;
        longint   scaled;
        for (int j = 0; j < LANES; j++) begin
            dot = 0;
            for (int n = 0; n < grp_beats.size(); n++) begin
                for (int k = 0; k < LANES; k++) begin
                    x   = grp_beats[n][k];
                    wt  = w[j][k];
                    dot = dot + x * wt;
                end
            end
            // 32-bit wrap on the bias add
            biased = dot + b[j];
            scaled = longint'(biased) * longint'(s[j]);
            r      = int'(scaled >>> SCALE_SHIFT);
            if (relu && (r < 0)) begin
                r = 0;
            end
            res[j] = r;
        end
        return res;
    endfunction

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic send_word(input word_kind_e kind, input logic [IDX_W-1:0] idx,
                             input logic [WORD_W-1:0] data);
        @(negedge clk_calc);
        in_vld   = 1'b1;
        in_kind  = kind;
        in_index = idx;
        in_data  = data;
    endtask

    task automatic idle_bus();
        @(negedge clk_calc);
        in_vld = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk_calc);
            n++;
            if (n > limit) begin
                $display("timeout: %0d result(s) of %s never came out", exp_q.size(), cur_name);
                stop_sim();
            end
        end
    endtask

    function automatic weight_mat_t ident_mat();
        weight_mat_t m;
        for (int j = 0; j < LANES; j++)
            for (int k = 0; k < LANES; k++)
                m[j][k] = (j == k) ? 8'sd1 : 8'sd0;
        return m;
    endfunction

    // row j picks lane 3-j with weight j+1 so a misplaced row shows up
    function automatic weight_mat_t swap_mat();
        weight_mat_t m;
        for (int j = 0; j < LANES; j++)
            for (int k = 0; k < LANES; k++)
                m[j][k] = (k == LANES - 1 - j) ? act_t'(j + 1) : 8'sd0;
        return m;
    endfunction

    function automatic scale_vec_t flat_scale(input int v);
        scale_vec_t s;
        for (int j = 0; j < LANES; j++)
            s[j] = scale_t'(v);
        return s;
    endfunction

    task automatic add_entry(input string name, input bit rand_w, input weight_mat_t w,
                             input acc_vec_t b, input scale_vec_t s, input bit relu,
                             input int len, input int groups, input bit rand_beats,
                             input act_vec_t beat);
        test_entry_t e;
        e = '{name, rand_w, w, b, s, relu, len, groups, rand_beats, beat};
        table_q.push_back(e);
    endtask

    // load coefficients, stream the groups and wait for every result
    task automatic run_entry(input test_entry_t e);
        weight_mat_t w;
        act_vec_t    beat;
        expect_t     item;
        int          len;
        cur_name = e.name;
        w = e.w;
        if (e.rand_w) begin
            for (int j = 0; j < LANES; j++)
                for (int k = 0; k < LANES; k++)
                    w[j][k] = act_t'($random(seed));
        end
        len = e.len;
        if (len == 0) begin
            len = 2 + ($unsigned($random(seed)) % 15);
        end
        // quasi-static controls change only while nothing is in flight
        @(negedge clk_calc);
        acc_len = LEN_W'(len);
        relu_en = e.relu;
        // rows in reverse order
        for (int j = LANES - 1; j >= 0; j--) begin
            send_word(KIND_WEIGHT, IDX_W'(j), WORD_W'(w[j]));
        end
        send_word(KIND_BIAS, '0, WORD_W'(e.b));
        send_word(KIND_SCALE, '0, WORD_W'(e.s));
        // groups go back to back
        for (int g = 0; g < e.groups; g++) begin
            grp_beats.delete();
            for (int n = 0; n < len; n++) begin
                beat = e.rand_beats ? act_vec_t'($random(seed)) : e.beat;
                grp_beats.push_back(beat);
                // junk above the activations
                send_word(KIND_DATA, '0, {$random(seed), $random(seed), $random(seed), beat});
            end
            // sampled on the next rise and out 5 rises later
            item.name  = e.name;
            item.data  = expected_result(w, e.b, e.s, e.relu);
            item.cycle = cycle_cnt + 6;
            exp_q.push_back(item);
        end
        idle_bus();
        wait_drain(200);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        rst_n    = 1'b0;
        in_vld   = 1'b0;
        in_kind  = KIND_DATA;
        in_index = '0;
        in_data  = '0;
        acc_len  = LEN_W'(1);
        relu_en  = 1'b0;

        add_entry("identity_one_beat", 0, ident_mat(), '0, flat_scale(256), 0, 1, 1, 0,
                  {8'h80, 8'sd3, 8'sd127, -8'sd5});
        add_entry("random_dot_a", 1, ident_mat(), '0, flat_scale(256), 0, 0, 1, 1, '0);
        add_entry("random_dot_b", 1, ident_mat(), '0, flat_scale(256), 0, 0, 1, 1, '0);
        add_entry("neg_bias_no_relu", 0, ident_mat(),
                  {32'sd0, -32'sd7, 32'sd50, -32'sd100},
                  {16'd77, 16'd1000, 16'd128, 16'd300}, 0, 3, 1, 0,
                  {-8'sd40, 8'sd30, -8'sd20, 8'sd10});
        add_entry("neg_bias_relu", 0, ident_mat(),
                  {32'sd0, -32'sd7, 32'sd50, -32'sd100},
                  {16'd77, 16'd1000, 16'd128, 16'd300}, 1, 3, 1, 0,
                  {-8'sd40, 8'sd30, -8'sd20, 8'sd10});
        add_entry("back_to_back", 1, ident_mat(), {32'sd9, -32'sd3, 32'sd0, 32'sd1},
                  flat_scale(256), 0, 2, 4, 1, '0);
        // one-beat groups give out_vld on consecutive cycles
        add_entry("single_beat_burst", 1, ident_mat(), '0, flat_scale(256), 0, 1, 3, 1, '0);
        // every row gives a distinct dot product with this beat
        add_entry("reload_row_order", 0, swap_mat(), {32'sd4, 32'sd3, 32'sd2, 32'sd1},
                  flat_scale(512), 0, 2, 1, 0, {8'sd7, 8'sd5, 8'sd3, 8'sd1});

        // monitor expects out_vld low through the 5 reset cycles
        repeat (5) @(posedge clk_calc);
        @(negedge clk_calc);
        rst_n = 1'b1;
        // idle after reset
        repeat (4) @(negedge clk_calc);

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end

        cur_name = "end_of_run";
        if (exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d expected result(s) still pending at the end", exp_q.size());
            stop_sim();
        end
    end

endmodule

`default_nettype wire

//--- build.f
acc_dims_pkg.sv
acc_stream_pkg.sv
coef_load_if.sv
rd_data_demux.sv
coef_bank.sv
mac_array.sv
bias_scale_relu.sv
mobilenet_acc_top.sv
tb_mobilenet_acc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_mobilenet_acc \
    -o tb_mobilenet_acc > build.log 2>&1 \
    && ./obj_dir/tb_mobilenet_acc > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

grep -q "^SIMULATION PASSED$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
